/* Bender.yml */
package:
  name: mini_cpu

sources:
  - files:
      - hw/mips_isa_pkg.sv
      - hw/core_ctrl_pkg.sv
      - hw/fetch_unit.sv
      - hw/exec_unit.sv
      - hw/mem_wb_unit.sv
      - hw/mini_cpu_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_mini_cpu.sv

/* files.f */
hw/mips_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/fetch_unit.sv
hw/exec_unit.sv
hw/mem_wb_unit.sv
hw/mini_cpu_top.sv
tb/clk_gen.sv
tb/tb_mini_cpu.sv

/* hw/core_ctrl_pkg.sv */
// core sequencing state enum, trace write enable and nop word constants
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,                       // only for lw and sw
        st_wb
    } core_state_e;

    // trace byte enables for a full register write
    localparam logic [3:0] wb_wen_all = 4'b1111;

    localparam logic [31:0] nop_word = 32'h0000_0000;   // sll r0,r0,0

endpackage

`default_nettype wire

/* hw/exec_unit.sv */
// exec_unit: decode, register file, ALU, beq resolution and next PC
`default_nettype none

module exec_unit (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic [31:0]           instr,
    input  logic [31:0]           pc,
    input  logic                  wb_we,
    input  logic [4:0]            wb_dst,
    input  logic [31:0]           wb_data,
    output logic [31:0]           alu_result,
    output logic [31:0]           store_data,
    output mips_isa_pkg::mem_op_e mem_op,
    output logic                  rf_we,
    output logic [4:0]            rf_dst,
    output logic [31:0]           next_pc
);

    mips_isa_pkg::opcode_e opcode;
    mips_isa_pkg::funct_e  funct;
    mips_isa_pkg::alu_op_e alu_op;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [31:0]           sext_imm;
    logic                  use_imm;
    logic                  is_beq;
    logic [31:0]           rs_val;
    logic [31:0]           rt_val;
    logic [31:0]           opb;
    logic [31:0]           pc_plus4;
    logic [31:0]           regs [1:31];             // r0 has no storage

    assign opcode   = mips_isa_pkg::opcode_e'(instr[mips_isa_pkg::op_lo +: 6]);
    assign funct    = mips_isa_pkg::funct_e'(instr[mips_isa_pkg::fn_lo +: 6]);
    assign rs       = instr[mips_isa_pkg::rs_lo +: 5];
    assign rt       = instr[mips_isa_pkg::rt_lo +: 5];
    assign rd       = instr[mips_isa_pkg::rd_lo +: 5];
    assign sext_imm = {{16{instr[mips_isa_pkg::imm_lo + 15]}}, instr[mips_isa_pkg::imm_lo +: 16]};

    always_comb begin
        alu_op  = mips_isa_pkg::alu_pass;
        mem_op  = mips_isa_pkg::mem_none;
        rf_we   = 1'b0;
        rf_dst  = rt;                               // I-type target by default
        use_imm = 1'b1;
        is_beq  = 1'b0;
        case (opcode)
            mips_isa_pkg::op_special: begin
                use_imm = 1'b0;
                rf_dst  = rd;
                rf_we   = 1'b1;
                case (funct)
                    mips_isa_pkg::fn_addu: alu_op = mips_isa_pkg::alu_add;
                    mips_isa_pkg::fn_subu: alu_op = mips_isa_pkg::alu_sub;
                    mips_isa_pkg::fn_and:  alu_op = mips_isa_pkg::alu_and;
                    mips_isa_pkg::fn_or:   alu_op = mips_isa_pkg::alu_or;
                    mips_isa_pkg::fn_slt:  alu_op = mips_isa_pkg::alu_slt;
                    default:               rf_we  = 1'b0;   // unknown funct is a no-op
                endcase
            end
            mips_isa_pkg::op_addiu: begin
                alu_op = mips_isa_pkg::alu_add;
                rf_we  = 1'b1;
            end
            mips_isa_pkg::op_lui: begin
                alu_op = mips_isa_pkg::alu_lui;
                rf_we  = 1'b1;
            end
            mips_isa_pkg::op_lw: begin
                alu_op = mips_isa_pkg::alu_add;     // base + offset
                mem_op = mips_isa_pkg::mem_load;
                rf_we  = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                alu_op = mips_isa_pkg::alu_add;
                mem_op = mips_isa_pkg::mem_store;
            end
            mips_isa_pkg::op_beq: begin
                use_imm = 1'b0;
                is_beq  = 1'b1;
            end
            default: ;                              // unknown opcode, pc+4 only
        endcase
    end

    // asynchronous read ports
    assign rs_val = (rs == 5'd0) ? 32'h0 : regs[rs];
    assign rt_val = (rt == 5'd0) ? 32'h0 : regs[rt];

    always_ff @(posedge aclk) begin
        if (wb_we && wb_dst != 5'd0) begin
            regs[wb_dst] <= wb_data;
        end
    end

    assign opb        = use_imm ? sext_imm : rt_val;
    assign store_data = rt_val;

    always_comb begin
        case (alu_op)
            mips_isa_pkg::alu_add:  alu_result = rs_val + opb;
            mips_isa_pkg::alu_sub:  alu_result = rs_val - opb;
            mips_isa_pkg::alu_and:  alu_result = rs_val & opb;
            mips_isa_pkg::alu_or:   alu_result = rs_val | opb;
            mips_isa_pkg::alu_slt:  alu_result = {31'h0, $signed(rs_val) < $signed(opb)};
            mips_isa_pkg::alu_lui:  alu_result = {opb[15:0], 16'h0000};
            default:                alu_result = opb;
        endcase
    end

    // no delay slot, target is relative to pc+4
    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = (is_beq && rs_val == rt_val) ? pc_plus4 + {sext_imm[29:0], 2'b00}
                                                   : pc_plus4;

    // write-back side drops r0 targets before they reach the port
    assert property (@(posedge aclk) disable iff (!arst_n) wb_we |-> wb_dst != 5'd0);

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
// fetch_unit: program counter, instruction request strobe and instruction latch
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        fetch_start,
    input  logic        pc_load,
    input  logic [31:0] next_pc,
    input  logic        imem_ok,
    input  logic [31:0] imem_rdata,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    output logic        fetch_done,
    output logic [31:0] instr,
    output logic [31:0] pc
);

    logic waiting;                                  // request out, word not back yet

    assign imem_addr  = pc;
    assign fetch_done = imem_ok && waiting;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            imem_req <= 1'b0;
            waiting  <= 1'b0;
        end else begin
            imem_req <= fetch_start;                // one cycle after the strobe
            if (imem_req) begin
                waiting <= 1'b1;
            end else if (imem_ok) begin
                waiting <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= reset_pc;
            instr <= core_ctrl_pkg::nop_word;
        end else begin
            if (pc_load) begin
                pc <= next_pc;                      // end of the wb step
            end
            if (fetch_done) begin
                instr <= imem_rdata;
            end
        end
    end

    // the sequencer must not start a second fetch while one is pending
    assert property (@(posedge aclk) disable iff (!arst_n) imem_req |-> !waiting);

    assert property (@(posedge aclk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/mem_wb_unit.sv */
// mem_wb_unit: data memory strobes, load latch, write-back select and debug trace
`default_nettype none

module mem_wb_unit (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic                  mem_start,
    input  logic                  wb_step,
    input  mips_isa_pkg::mem_op_e mem_op,
    input  logic [31:0]           alu_result,
    input  logic [31:0]           store_data,
    input  logic                  rf_we,
    input  logic [4:0]            rf_dst,
    input  logic [31:0]           pc,
    input  logic                  dmem_ok,
    input  logic [31:0]           dmem_rdata,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output logic [31:0]           dmem_addr,
    output logic [31:0]           dmem_wdata,
    output logic                  access_done,
    output logic                  wb_we,
    output logic [4:0]            wb_dst,
    output logic [31:0]           wb_data,
    output logic [31:0]           debug_wb_pc,
    output logic [31:0]           debug_wb_rf_wdata,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [4:0]            debug_wb_rf_wnum
);

    logic        pending;                           // waiting for dmem_ok
    logic [31:0] load_data;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
            pending  <= 1'b0;
        end else begin
            dmem_req <= mem_start;                  // first mem cycle
            if (mem_start) begin
                dmem_we <= (mem_op == mips_isa_pkg::mem_store);
                pending <= 1'b1;
            end else if (access_done) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_start) begin
            dmem_addr  <= alu_result;
            dmem_wdata <= store_data;
        end
        if (access_done) begin
            load_data <= dmem_rdata;                // stores ignore it
        end
    end

    assign access_done = dmem_ok && pending;

    // r0 writes vanish here, so no trace pulse either
    assign wb_we   = wb_step && rf_we && (rf_dst != 5'd0);
    assign wb_dst  = rf_dst;
    assign wb_data = (mem_op == mips_isa_pkg::mem_load) ? load_data : alu_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wen   = wb_we ? core_ctrl_pkg::wb_wen_all : 4'b0000;
    assign debug_wb_rf_wnum  = wb_dst;

    assert property (@(posedge aclk) disable iff (!arst_n)
        dmem_req |-> mem_op != mips_isa_pkg::mem_none);

    // no sub-word accesses in this subset
    assert property (@(posedge aclk) disable iff (!arst_n) dmem_req |-> dmem_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/mini_cpu_top.sv */
// mini_cpu_top: sequencing FSM and fetch, exec and mem/wb unit instances
`default_nettype none

module mini_cpu_top #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        aclk,
    input  logic        arst_n,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_ok,
    input  logic [31:0] imem_rdata,
    output logic        dmem_req,
    output logic        dmem_we,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic        dmem_ok,
    input  logic [31:0] dmem_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [31:0] debug_wb_rf_wdata,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum
);

    core_ctrl_pkg::core_state_e state;
    core_ctrl_pkg::core_state_e state_next;
    mips_isa_pkg::mem_op_e      mem_op;

    logic        fetch_start;
    logic        fetch_done;
    logic        exec_step;
    logic        mem_start;
    logic        wb_step;
    logic        access_done;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] alu_result;
    logic [31:0] store_data;
    logic        rf_we;
    logic [4:0]  rf_dst;
    logic        wb_we;
    logic [4:0]  wb_dst;
    logic [31:0] wb_data;

    assign exec_step = (state == core_ctrl_pkg::st_exec);
    assign wb_step   = (state == core_ctrl_pkg::st_wb);
    assign mem_start = exec_step && (mem_op != mips_isa_pkg::mem_none);

    always_comb begin
        state_next = state;
        case (state)
            core_ctrl_pkg::st_fetch: if (fetch_done)  state_next = core_ctrl_pkg::st_exec;
            core_ctrl_pkg::st_exec:  state_next = mem_start ? core_ctrl_pkg::st_mem
                                                            : core_ctrl_pkg::st_wb;
            core_ctrl_pkg::st_mem:   if (access_done) state_next = core_ctrl_pkg::st_wb;
            default:                 state_next = core_ctrl_pkg::st_fetch;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= core_ctrl_pkg::st_fetch;
            fetch_start <= 1'b1;                    // first request right after reset
        end else begin
            state       <= state_next;
            fetch_start <= wb_step;                 // first cycle of each fetch
        end
    end

    fetch_unit #(
        .reset_pc    (reset_pc)
    ) u_fetch (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .fetch_start (fetch_start),
        .pc_load     (wb_step),
        .next_pc     (next_pc),
        .imem_ok     (imem_ok),
        .imem_rdata  (imem_rdata),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .fetch_done  (fetch_done),
        .instr       (instr),
        .pc          (pc)
    );

    exec_unit u_exec (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .instr       (instr),
        .pc          (pc),
        .wb_we       (wb_we),
        .wb_dst      (wb_dst),
        .wb_data     (wb_data),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .mem_op      (mem_op),
        .rf_we       (rf_we),
        .rf_dst      (rf_dst),
        .next_pc     (next_pc)
    );

    mem_wb_unit u_mem_wb (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .mem_start         (mem_start),
        .wb_step           (wb_step),
        .mem_op            (mem_op),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .rf_we             (rf_we),
        .rf_dst            (rf_dst),
        .pc                (pc),
        .dmem_ok           (dmem_ok),
        .dmem_rdata        (dmem_rdata),
        .dmem_req          (dmem_req),
        .dmem_we           (dmem_we),
        .dmem_addr         (dmem_addr),
        .dmem_wdata        (dmem_wdata),
        .access_done       (access_done),
        .wb_we             (wb_we),
        .wb_dst            (wb_dst),
        .wb_data           (wb_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

/* hw/mips_isa_pkg.sv */
// MIPS32 subset encodings: opcode, funct, ALU op and memory op enums, field positions
`default_nettype none

package mips_isa_pkg;

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,           // R-type, funct selects
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,                      // signed compare
        alu_lui,                      // imm into upper half
        alu_pass                      // operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    // low bit of each instruction field
    localparam int unsigned op_lo  = 26;
    localparam int unsigned rs_lo  = 21;
    localparam int unsigned rt_lo  = 16;
    localparam int unsigned rd_lo  = 11;
    localparam int unsigned fn_lo  = 0;
    localparam int unsigned imm_lo = 0;

endpackage

`default_nettype wire

/* tb/clk_gen.sv */
// clk_gen: free-running testbench clock
`default_nettype none

module clk_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;            // half period per edge
        end
    end

endmodule

`default_nettype wire

/* tb/program_input.txt */
// hex words for $readmemh: @010 program words from reset_pc 0x40, @100 data memory words
// @180 expected trace, one entry per line as: pc  register  value, closed by ffffffff
@010
24010005    // 0x40 addiu r1, r0, 5
2402fffd    // 0x44 addiu r2, r0, -3
00221821    // 0x48 addu  r3, r1, r2
00222023    // 0x4c subu  r4, r1, r2
3c051234    // 0x50 lui   r5, 0x1234
24a55678    // 0x54 addiu r5, r5, 0x5678
00a43024    // 0x58 and   r6, r5, r4
00243825    // 0x5c or    r7, r1, r4
0041402a    // 0x60 slt   r8, r2, r1
0022482a    // 0x64 slt   r9, r1, r2
ac050020    // 0x68 sw    r5, 0x20(r0)
8c0a0020    // 0x6c lw    r10, 0x20(r0)
8c0b0010    // 0x70 lw    r11, 0x10(r0)
24200007    // 0x74 addiu r0, r1, 7
00016021    // 0x78 addu  r12, r0, r1
10230001    // 0x7c beq   r1, r3, +1 (not taken)
240d0011    // 0x80 addiu r13, r0, 0x11
10630001    // 0x84 beq   r3, r3, +1 (taken)
240e0099    // 0x88 addiu r14, r0, 0x99 (skipped)
240f0022    // 0x8c addiu r15, r0, 0x22
ac8b001c    // 0x90 sw    r11, 0x1c(r4)
8c100024    // 0x94 lw    r16, 0x24(r0)
fc000000    // 0x98 unknown opcode
020b8823    // 0x9c subu  r17, r16, r11
1000ffff    // 0xa0 beq   r0, r0, -1 (spin)
@104
89abcdef    // data word at byte address 0x10
@180
00000040 01 00000005
00000044 02 fffffffd
00000048 03 00000002
0000004c 04 00000008
00000050 05 12340000
00000054 05 12345678
00000058 06 00000008
0000005c 07 0000000d
00000060 08 00000001
00000064 09 00000000
0000006c 0a 12345678
00000070 0b 89abcdef
00000078 0c 00000005
00000080 0d 00000011
0000008c 0f 00000022
00000094 10 89abcdef
0000009c 11 00000000
ffffffff

/* tb/tb_mini_cpu.sv */
// tb_mini_cpu: memory models, write-back trace checking, watchdog and summary
`default_nettype none

module tb_mini_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_pc      = 32'h0000_0040;
    localparam int          reset_cycles  = 16;
    localparam int          imem_words    = 256;
    localparam int          dmem_words    = 64;
    localparam int          input_words_n = 512;
    localparam int          dmem_base     = 'h100;  // word offsets inside the input file
    localparam int          trace_base    = 'h180;
    localparam int          max_entries   = 42;
    localparam int          tail_cycles   = 40;     // quiet time after the last entry
    localparam int          drive_delay   = 2;
    localparam int          sample_delay  = 1;

    logic        aclk;
    logic        arst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ok;
    logic [31:0] imem_rdata;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ok;
    logic [31:0] dmem_rdata;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] input_words [0:input_words_n-1];
    logic [31:0] imem [0:imem_words-1];
    logic [31:0] dmem [0:dmem_words-1];
    logic [31:0] exp_pc [0:max_entries-1];
    logic [4:0]  exp_num [0:max_entries-1];
    logic [31:0] exp_data [0:max_entries-1];

    int n_expected   = 0;
    int seen         = 0;
    int mismatches   = 0;
    int other_errors = 0;
    int seed         = 4297;

    clk_gen #(
        .period_ns (40)
    ) u_clk_gen (
        .clk (aclk)
    );

    mini_cpu_top #(
        .reset_pc          (reset_pc)
    ) u_mini_cpu_top (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .imem_req          (imem_req),
        .imem_addr         (imem_addr),
        .imem_ok           (imem_ok),
        .imem_rdata        (imem_rdata),
        .dmem_req          (dmem_req),
        .dmem_we           (dmem_we),
        .dmem_addr         (dmem_addr),
        .dmem_wdata        (dmem_wdata),
        .dmem_ok           (dmem_ok),
        .dmem_rdata        (dmem_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    function automatic int unsigned draw_latency();
        return 1 + ({$random(seed)} % 4);           // 1 to 4 cycles
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, expected);
        mismatches++;
    endtask

    task automatic report_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        other_errors++;
    endtask

    task automatic report_and_finish();
        $display("summary: %0d mismatches, %0d other errors, %0d of %0d trace entries checked",
                 mismatches, other_errors, seen, n_expected);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic load_input();
        int i;
        for (i = 0; i < input_words_n; i++) begin
            input_words[i] = 32'hbad0_0000 | i;     // unloaded words show their own address
        end
        $readmemh("tb/program_input.txt", input_words);
        for (i = 0; i < imem_words; i++) begin
            imem[i] = input_words[i];
        end
        for (i = 0; i < dmem_words; i++) begin
            dmem[i] = input_words[dmem_base + i];
        end
        // triples of pc, register, value up to the ffffffff marker
        while (n_expected < max_entries &&
               input_words[trace_base + 3 * n_expected] !== 32'hffff_ffff) begin
            exp_pc[n_expected]   = input_words[trace_base + 3 * n_expected];
            exp_num[n_expected]  = input_words[trace_base + 3 * n_expected + 1][4:0];
            exp_data[n_expected] = input_words[trace_base + 3 * n_expected + 2];
            n_expected++;
        end
        assert (n_expected > 0) else report_failure("no expected trace entries in the input file");
    endtask

    task automatic check_trace_entry();
        if (seen >= n_expected) begin
            report_failure("register write beyond the end of the expected trace");
        end else begin
            assert (debug_wb_pc === exp_pc[seen])
                else report_mismatch("debug_wb_pc", debug_wb_pc, exp_pc[seen]);
            assert (debug_wb_rf_wnum === exp_num[seen])
                else report_mismatch("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num[seen]);
            assert (debug_wb_rf_wdata === exp_data[seen])
                else report_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[seen]);
            assert (debug_wb_rf_wen === 4'b1111)
                else report_mismatch("debug_wb_rf_wen", debug_wb_rf_wen, 32'hf);
            seen++;
        end
    endtask

    initial begin : stimulus
        arst_n     = 1'b0;
        imem_ok    = 1'b0;
        imem_rdata = 32'h0;
        dmem_ok    = 1'b0;
        dmem_rdata = 32'h0;
        load_input();
        repeat (reset_cycles) begin
            @(posedge aclk);
            #sample_delay;
            assert (imem_req === 1'b0 && dmem_req === 1'b0 && debug_wb_rf_wen === 4'b0000)
                else report_failure("memory strobe or trace pulse active during reset");
        end
        #(drive_delay - sample_delay);
        arst_n = 1'b1;
        wait (seen == n_expected);
        repeat (tail_cycles) @(posedge aclk);       // spin loop must stay silent
        report_and_finish();
    end

    initial begin : memory_models
        int unsigned imem_wait;
        int unsigned dmem_wait;
        logic [31:0] ireq_addr;
        logic [31:0] dreq_addr;
        logic [31:0] dreq_wdata;
        logic        dreq_we;
        logic        first_fetch;
        imem_wait   = 0;
        dmem_wait   = 0;
        ireq_addr   = 32'h0;
        dreq_addr   = 32'h0;
        dreq_wdata  = 32'h0;
        dreq_we     = 1'b0;
        first_fetch = 1'b1;
        forever begin
            @(posedge aclk);
            #drive_delay;
            imem_ok = 1'b0;                         // ok pulses last one cycle
            dmem_ok = 1'b0;
            if (imem_req === 1'b1) begin
                assert (imem_wait == 0)
                    else report_failure("instruction request while one is outstanding");
                if (first_fetch) begin
                    assert (imem_addr === reset_pc)
                        else report_mismatch("imem_addr", imem_addr, reset_pc);
                    first_fetch = 1'b0;
                end
                assert (imem_addr[31:2] < imem_words)
                    else report_failure("instruction fetch outside program memory");
                ireq_addr = imem_addr;
                imem_wait = draw_latency();
            end else if (imem_wait != 0) begin
                imem_wait = imem_wait - 1;
                if (imem_wait == 0) begin
                    imem_ok    = 1'b1;
                    imem_rdata = imem[ireq_addr[9:2]];
                end
            end
            if (dmem_req === 1'b1) begin
                assert (dmem_wait == 0)
                    else report_failure("data request while one is outstanding");
                assert (dmem_addr[31:2] < dmem_words)
                    else report_failure("data access outside data memory");
                dreq_addr  = dmem_addr;
                dreq_we    = dmem_we;
                dreq_wdata = dmem_wdata;
                dmem_wait  = draw_latency();
            end else if (dmem_wait != 0) begin
                dmem_wait = dmem_wait - 1;
                if (dmem_wait == 0) begin
                    if (dreq_we) begin
                        dmem[dreq_addr[7:2]] = dreq_wdata;
                    end
                    dmem_ok    = 1'b1;
                    dmem_rdata = dmem[dreq_addr[7:2]];
                end
            end
        end
    end

    initial begin : trace_checker
        forever begin
            @(posedge aclk);
            #sample_delay;
            if (arst_n === 1'b1 && debug_wb_rf_wen !== 4'b0000) begin
                check_trace_entry();
            end
        end
    end

    initial begin : watchdog
        wait (arst_n === 1'b1);
        repeat (n_expected * 12 + 100) @(posedge aclk);
        report_failure($sformatf("timeout, the trace did not complete (%0d of %0d entries)",
                                 seen, n_expected));
        report_and_finish();
    end

endmodule

`default_nettype wire
